//--- hdl/cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// Base sizes
`define CACHE_WORD_W       32
`define CACHE_BLOCK_WORDS  4
`define CACHE_SETS         16
`define CACHE_WAYS         4
`define CACHE_MEM_CREDITS  2  // Memory request credits after reset

// Derived field widths
`define CACHE_BYTE_W    ($clog2(`CACHE_WORD_W / 8))
`define CACHE_OFFSET_W  ($clog2(`CACHE_BLOCK_WORDS))
`define CACHE_INDEX_W   ($clog2(`CACHE_SETS))
`define CACHE_AGE_W     ($clog2(`CACHE_WAYS))
`define CACHE_TAG_W     (`CACHE_WORD_W - `CACHE_INDEX_W - `CACHE_OFFSET_W - `CACHE_BYTE_W)
`define CACHE_LINE_W    (`CACHE_WORD_W * `CACHE_BLOCK_WORDS)

`endif

//--- hdl/cache_pkg.sv
`default_nettype none

`include "cache_cfg.svh"

package cache_pkg;

  // Address split as seen by the cache
  typedef struct packed {
    logic [`CACHE_TAG_W-1:0]    tag;
    logic [`CACHE_INDEX_W-1:0]  index;
    logic [`CACHE_OFFSET_W-1:0] word;
    logic [`CACHE_BYTE_W-1:0]   byte_off;
  } cache_addr_f_t;

  // Raw view for the memory port, field view for lookup
  typedef union packed {
    logic [`CACHE_WORD_W-1:0] raw;
    cache_addr_f_t            f;
  } cache_addr_u;

  typedef struct packed {
    logic                    valid;
    logic                    dirty;
    logic [`CACHE_AGE_W-1:0] age;  // 0 is youngest
    logic [`CACHE_TAG_W-1:0] tag;
  } line_meta_t;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    EVICT,
    ALLOCATE,
    FILL
  } ctrl_state_e;

endpackage

`default_nettype wire

//--- hdl/way_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

interface way_if
  import cache_pkg::*;
();

  // Candidates of the registered set
  line_meta_t                cand_meta [`CACHE_WAYS];
  logic [`CACHE_LINE_W-1:0]  cand_data [`CACHE_WAYS];

  // Line write-back and age update
  logic                      wr_en;
  logic [`CACHE_WAYS-1:0]    wr_way;  // One-hot
  line_meta_t                wr_meta;
  logic [`CACHE_LINE_W-1:0]  wr_data;
  logic [`CACHE_AGE_W-1:0]   new_age [`CACHE_WAYS];

  modport storage (output cand_meta, cand_data,
                   input  wr_en, wr_way, wr_meta, wr_data, new_age);

  modport select  (input  cand_meta, cand_data,
                   output wr_en, wr_way, wr_meta, wr_data, new_age);

endinterface

`default_nettype wire

//--- hdl/way_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module way_array
  import cache_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      rd_en,
  input  logic [`CACHE_INDEX_W-1:0] index,
  way_if.storage                    ways
);

  localparam int AGE_W = `CACHE_AGE_W;

  line_meta_t               meta_q [`CACHE_SETS][`CACHE_WAYS];
  logic [`CACHE_LINE_W-1:0] data_q [`CACHE_SETS][`CACHE_WAYS];
  logic [`CACHE_WAYS-1:0]   age_seen;

  // Every set starts invalid with way w at age w
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < `CACHE_SETS; s++) begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
          meta_q[s][w] <= '{valid: 1'b0, dirty: 1'b0, age: w[AGE_W-1:0], tag: '0};
        end
      end
    end else if (ways.wr_en) begin
      for (int w = 0; w < `CACHE_WAYS; w++) begin
        if (ways.wr_way[w]) begin
          meta_q[index][w] <= ways.wr_meta;
        end else begin
          meta_q[index][w].age <= ways.new_age[w];  // Other ways only age
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ways.wr_en) begin
      for (int w = 0; w < `CACHE_WAYS; w++) begin
        if (ways.wr_way[w]) data_q[index][w] <= ways.wr_data;
      end
    end
  end

  // Registered read of the whole set
  always_ff @(posedge clk) begin
    if (rd_en) begin
      for (int w = 0; w < `CACHE_WAYS; w++) begin
        ways.cand_meta[w] <= meta_q[index][w];
        ways.cand_data[w] <= data_q[index][w];
      end
    end
  end

  always_comb begin
    age_seen = '0;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      age_seen[ways.cand_meta[w].age] = 1'b1;
    end
  end

  // Ages of a freshly read set must stay a permutation of 0..WAYS-1
  a_age_perm: assert property (@(posedge clk) disable iff (!rst_n) rd_en |=> &age_seen);

endmodule

`default_nettype wire

//--- hdl/way_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module way_select
  import cache_pkg::*;
(
  input  cache_addr_u               addr,
  input  logic                      write,
  input  logic [`CACHE_WORD_W-1:0]  wdata,
  input  logic [`CACHE_LINE_W-1:0]  fill_data,
  input  logic                      fill,
  input  logic                      lookup,
  way_if.select                     ways,
  output logic                      hit,
  output logic [`CACHE_WAYS-1:0]    hit_way,
  output logic [`CACHE_WAYS-1:0]    victim_way,
  output logic                      victim_dirty,
  output logic [`CACHE_TAG_W-1:0]   victim_tag,
  output logic [`CACHE_LINE_W-1:0]  victim_data,
  output logic [`CACHE_WORD_W-1:0]  rd_word
);

  localparam int AGE_W = `CACHE_AGE_W;

  logic [`CACHE_WAYS-1:0]   touched;
  line_meta_t               touched_meta;
  logic [`CACHE_LINE_W-1:0] touched_data;
  line_meta_t               victim_meta;
  logic [AGE_W-1:0]         old_age;

  always_comb begin
    hit_way    = '0;
    victim_way = '0;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      hit_way[w]    = ways.cand_meta[w].valid && (ways.cand_meta[w].tag == addr.f.tag);
      victim_way[w] = (ways.cand_meta[w].age == '1);  // Oldest way
    end
  end

  assign hit     = |hit_way;
  assign touched = fill ? victim_way : hit_way;

  // One-hot muxes over the candidates
  always_comb begin
    touched_meta = '0;
    touched_data = '0;
    victim_meta  = '0;
    victim_data  = '0;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (touched[w]) begin
        touched_meta = ways.cand_meta[w];
        touched_data = ways.cand_data[w];
      end
      if (victim_way[w]) begin
        victim_meta = ways.cand_meta[w];
        victim_data = ways.cand_data[w];
      end
    end
  end

  assign victim_dirty = victim_meta.valid & victim_meta.dirty;
  assign victim_tag   = victim_meta.tag;

  // A refill replaces the oldest way, so every younger way ages
  assign old_age = fill ? '1 : touched_meta.age;

  always_comb begin
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (touched[w]) begin
        ways.new_age[w] = '0;
      end else if (ways.cand_meta[w].age < old_age) begin
        ways.new_age[w] = ways.cand_meta[w].age + 1'b1;
      end else begin
        ways.new_age[w] = ways.cand_meta[w].age;
      end
    end
  end

  // Line to install, with the CPU word merged on a write
  always_comb begin
    ways.wr_data = fill ? fill_data : touched_data;
    if (write) ways.wr_data[addr.f.word*`CACHE_WORD_W +: `CACHE_WORD_W] = wdata;
    ways.wr_meta = '{valid: 1'b1,
                     dirty: fill ? write : (touched_meta.dirty | write),
                     age:   '0,
                     tag:   addr.f.tag};
  end

  assign ways.wr_en  = fill | (lookup & hit);  // Read hits also rewrite for the age update
  assign ways.wr_way = touched;

  assign rd_word = ways.wr_data[addr.f.word*`CACHE_WORD_W +: `CACHE_WORD_W];

endmodule

`default_nettype wire

//--- hdl/cache_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module cache_fsm
  import cache_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  // CPU side
  input  logic                      cpu_req_valid,
  output logic                      cpu_req_ready,
  input  cache_addr_u               cpu_req_addr,
  input  logic                      cpu_req_write,
  input  logic [`CACHE_WORD_W-1:0]  cpu_req_wdata,
  output logic                      cpu_rsp_valid,
  output logic [`CACHE_WORD_W-1:0]  cpu_rsp_rdata,
  // Memory side
  output logic                      mem_req_valid,
  output logic                      mem_req_write,
  output logic [`CACHE_WORD_W-1:0]  mem_req_addr,
  output logic [`CACHE_LINE_W-1:0]  mem_req_wdata,
  input  logic                      mem_credit,
  input  logic                      mem_rsp_valid,
  input  logic [`CACHE_LINE_W-1:0]  mem_rsp_rdata,
  // Storage and selection
  output logic                      rd_en,
  output logic [`CACHE_INDEX_W-1:0] index,
  output cache_addr_u               req_addr,
  output logic                      req_write,
  output logic [`CACHE_WORD_W-1:0]  req_wdata,
  output logic                      lookup,
  input  logic                      hit,
  input  logic                      victim_dirty,
  input  logic [`CACHE_TAG_W-1:0]   victim_tag,
  input  logic [`CACHE_LINE_W-1:0]  victim_data,
  input  logic [`CACHE_WORD_W-1:0]  rd_word,
  output logic                      fill,
  output logic [`CACHE_LINE_W-1:0]  fill_data
);

  localparam int CREDIT_W = $clog2(`CACHE_MEM_CREDITS + 1);
  localparam logic [CREDIT_W-1:0] CREDIT_MAX = CREDIT_W'(`CACHE_MEM_CREDITS);

  ctrl_state_e         state_q;
  ctrl_state_e         state_d;
  logic [CREDIT_W-1:0] credit_q;
  logic                rd_sent_q;  // Block read issued in this ALLOCATE
  logic                accept;
  logic                rsp_take;
  logic                rsp_now;
  cache_addr_u         wb_addr;
  cache_addr_u         blk_addr;

  assign cpu_req_ready = (state_q == IDLE);
  assign accept        = cpu_req_valid & cpu_req_ready;
  assign rd_en         = accept;
  assign lookup        = (state_q == LOOKUP);
  assign fill          = (state_q == FILL);
  assign rsp_take      = (state_q == ALLOCATE) & rd_sent_q & mem_rsp_valid;
  assign rsp_now       = (lookup & hit) | fill;

  // Incoming index is read at acceptance, afterwards the held one is used
  assign index = (state_q == IDLE) ? cpu_req_addr.f.index : req_addr.f.index;

  always_comb begin
    wb_addr            = req_addr;
    wb_addr.f.tag      = victim_tag;
    wb_addr.f.word     = '0;
    wb_addr.f.byte_off = '0;
    blk_addr            = req_addr;
    blk_addr.f.word     = '0;
    blk_addr.f.byte_off = '0;
  end

  assign mem_req_valid = (credit_q != '0) &&
                         ((state_q == EVICT) || ((state_q == ALLOCATE) && !rd_sent_q));
  assign mem_req_write = (state_q == EVICT);
  assign mem_req_addr  = mem_req_write ? wb_addr.raw : blk_addr.raw;
  assign mem_req_wdata = victim_data;  // Victim line for write-back

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:     if (accept) state_d = LOOKUP;
      LOOKUP: begin
        if (hit)               state_d = IDLE;
        else if (victim_dirty) state_d = EVICT;
        else                   state_d = ALLOCATE;
      end
      EVICT:    if (mem_req_valid) state_d = ALLOCATE;  // Holds without credit
      ALLOCATE: if (rsp_take) state_d = FILL;
      FILL:     state_d = IDLE;
      default:  state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q       <= IDLE;
      credit_q      <= CREDIT_MAX;
      rd_sent_q     <= 1'b0;
      cpu_rsp_valid <= 1'b0;
    end else begin
      state_q       <= state_d;
      cpu_rsp_valid <= rsp_now;
      case ({mem_req_valid, mem_credit})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: credit_q <= credit_q;  // Spend and return cancel
      endcase
      if (state_q != ALLOCATE) begin
        rd_sent_q <= 1'b0;
      end else if (mem_req_valid) begin
        rd_sent_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req_addr  <= cpu_req_addr;
      req_write <= cpu_req_write;
      req_wdata <= cpu_req_wdata;
    end
    if (rsp_take) fill_data <= mem_rsp_rdata;
    if (rsp_now) cpu_rsp_rdata <= req_write ? '0 : rd_word;  // Writes only acknowledge
  end

  // With no credit left and none returned the next cycle stays quiet
  a_credit_avail: assert property (@(posedge clk) disable iff (!rst_n)
    (credit_q == '0) && !mem_credit |=> !mem_req_valid);

  // Memory must not return more credits than it was given
  a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
    credit_q <= CREDIT_MAX);

  // A response closes a request that was in flight
  a_rsp_origin: assert property (@(posedge clk) disable iff (!rst_n)
    cpu_rsp_valid |-> cpu_req_ready && $past(!cpu_req_ready));

endmodule

`default_nettype wire

//--- hdl/cache_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module cache_top
  import cache_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  // CPU side
  input  logic                     cpu_req_valid,
  output logic                     cpu_req_ready,
  input  logic [`CACHE_WORD_W-1:0] cpu_req_addr,
  input  logic                     cpu_req_write,
  input  logic [`CACHE_WORD_W-1:0] cpu_req_wdata,
  output logic                     cpu_rsp_valid,
  output logic [`CACHE_WORD_W-1:0] cpu_rsp_rdata,
  // Memory side
  output logic                     mem_req_valid,
  output logic                     mem_req_write,
  output logic [`CACHE_WORD_W-1:0] mem_req_addr,
  output logic [`CACHE_LINE_W-1:0] mem_req_wdata,
  input  logic                     mem_credit,
  input  logic                     mem_rsp_valid,
  input  logic [`CACHE_LINE_W-1:0] mem_rsp_rdata
);

  logic                      rd_en;
  logic [`CACHE_INDEX_W-1:0] index;
  cache_addr_u               req_addr;
  logic                      req_write;
  logic [`CACHE_WORD_W-1:0]  req_wdata;
  logic                      lookup;
  logic                      fill;
  logic [`CACHE_LINE_W-1:0]  fill_data;
  logic                      hit;
  logic                      victim_dirty;
  logic [`CACHE_TAG_W-1:0]   victim_tag;
  logic [`CACHE_LINE_W-1:0]  victim_data;
  logic [`CACHE_WORD_W-1:0]  rd_word;

  way_if ways_if ();

  way_array way_array_i (
    .clk   (clk),
    .rst_n (rst_n),
    .rd_en (rd_en),
    .index (index),
    .ways  (ways_if)
  );

  // Way vectors stay internal to the selection logic
  way_select way_select_i (
    .addr         (req_addr),
    .write        (req_write),
    .wdata        (req_wdata),
    .fill_data    (fill_data),
    .fill         (fill),
    .lookup       (lookup),
    .ways         (ways_if),
    .hit          (hit),
    .hit_way      (),
    .victim_way   (),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag),
    .victim_data  (victim_data),
    .rd_word      (rd_word)
  );

  cache_fsm cache_fsm_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .cpu_req_valid (cpu_req_valid),
    .cpu_req_ready (cpu_req_ready),
    .cpu_req_addr  (cpu_req_addr),
    .cpu_req_write (cpu_req_write),
    .cpu_req_wdata (cpu_req_wdata),
    .cpu_rsp_valid (cpu_rsp_valid),
    .cpu_rsp_rdata (cpu_rsp_rdata),
    .mem_req_valid (mem_req_valid),
    .mem_req_write (mem_req_write),
    .mem_req_addr  (mem_req_addr),
    .mem_req_wdata (mem_req_wdata),
    .mem_credit    (mem_credit),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp_rdata (mem_rsp_rdata),
    .rd_en         (rd_en),
    .index         (index),
    .req_addr      (req_addr),
    .req_write     (req_write),
    .req_wdata     (req_wdata),
    .lookup        (lookup),
    .hit           (hit),
    .victim_dirty  (victim_dirty),
    .victim_tag    (victim_tag),
    .victim_data   (victim_data),
    .rd_word       (rd_word),
    .fill          (fill),
    .fill_data     (fill_data)
  );

endmodule

`default_nettype wire

//--- verification/tb_cache.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module tb_cache
  import cache_pkg::*;
();

  localparam int NUM_RAND    = 200;
  localparam int NUM_REQ     = NUM_RAND + 20;
  localparam int WORST_MISS  = 40;  // Write-back, read, credit and memory delays
  localparam int LIMIT       = NUM_REQ * WORST_MISS + 500;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  logic clk;
  logic rst_n;
  logic cpu_req_valid, cpu_req_ready, cpu_req_write, cpu_rsp_valid;
  logic [31:0] cpu_req_addr, cpu_req_wdata, cpu_rsp_rdata;
  logic mem_req_valid, mem_req_write, mem_credit, mem_rsp_valid;
  logic [31:0] mem_req_addr;
  logic [127:0] mem_req_wdata, mem_rsp_rdata;

  int cyc = 0;
  int err_cnt = 0;
  int mem_req_cnt = 0;
  bit hold_credits = 0;
  logic [31:0] stim_lfsr = 32'd1;
  logic [31:0] delay_lfsr = 32'd1;

  // Expected results from the reference model
  logic [31:0] exp_rsp[$];
  cache_addr_u exp_mem_addr[$];
  logic exp_mem_wr[$];
  logic [127:0] exp_mem_data[$];

  line_meta_t ref_meta [`CACHE_SETS][`CACHE_WAYS];
  logic [127:0] ref_data [`CACHE_SETS][`CACHE_WAYS];
  logic [127:0] ref_mem [int unsigned];
  logic [127:0] mem_blk [int unsigned];  // Blocks written back by the DUT
  int credit_due[$];
  int rsp_due[$];
  logic [127:0] rsp_data[$];

  cache_top cache_top_i (.*);

  initial begin
    clk = 0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  function automatic logic [31:0] lfsr_bits(inout logic [31:0] state, input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], state[0]};
      state = state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
    end
    return val;
  endfunction

  // Default memory contents, every word depends on the full block address
  function automatic logic [127:0] init_block(logic [31:0] b);
    logic [127:0] blk;
    for (int w = 0; w < 4; w++) begin
      blk[w*32 +: 32] = (b * 32'h9e37_79b1) ^ (w * 32'h0100_0193) ^ {b[15:0], b[31:16]};
    end
    return blk;
  endfunction

  function automatic logic [31:0] ref_access(cache_addr_u a, logic wr, logic [31:0] wd);
    int s;
    int hw;
    int tw;
    logic [1:0] old_age;
    logic dirty;
    logic [127:0] line;
    cache_addr_u wb;
    cache_addr_u blk;
    s = a.f.index;
    hw = -1;
    tw = 0;
    for (int w = 0; w < 4; w++) begin
      if (ref_meta[s][w].valid && ref_meta[s][w].tag == a.f.tag) hw = w;
      if (ref_meta[s][w].age == 2'd3) tw = w;  // Oldest way is the victim
    end
    if (hw >= 0) begin
      tw = hw;
      old_age = ref_meta[s][tw].age;
      line = ref_data[s][tw];
      dirty = ref_meta[s][tw].dirty;
    end else begin
      if (ref_meta[s][tw].valid && ref_meta[s][tw].dirty) begin
        wb.raw = '0;
        wb.f.tag = ref_meta[s][tw].tag;
        wb.f.index = a.f.index;
        exp_mem_addr.push_back(wb);
        exp_mem_wr.push_back(1'b1);
        exp_mem_data.push_back(ref_data[s][tw]);
        ref_mem[wb.raw] = ref_data[s][tw];
      end
      blk = a;
      blk.f.word = '0;
      blk.f.byte_off = '0;
      exp_mem_addr.push_back(blk);
      exp_mem_wr.push_back(1'b0);
      exp_mem_data.push_back('0);
      line = ref_mem.exists(blk.raw) ? ref_mem[blk.raw] : init_block(blk.raw);
      old_age = 2'd3;
      dirty = 1'b0;
    end
    if (wr) begin
      line[a.f.word*32 +: 32] = wd;
      dirty = 1'b1;
    end
    for (int w = 0; w < 4; w++) begin
      if (w != tw && ref_meta[s][w].age < old_age) ref_meta[s][w].age++;
    end
    ref_meta[s][tw] = '{valid: 1'b1, dirty: dirty, age: 2'd0, tag: a.f.tag};
    ref_data[s][tw] = line;
    return wr ? 32'h0 : line[a.f.word*32 +: 32];
  endfunction

  task automatic check_word(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("Error %s: got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("Error %s: got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_mem_req(cache_addr_u got_addr, logic got_wr, logic [127:0] got_data,
                               cache_addr_u exp_addr, logic exp_wr, logic [127:0] exp_data);
    if (got_addr.raw !== exp_addr.raw || got_wr !== exp_wr) begin
      $display("Error mem_req_addr/mem_req_write: got %h/%h expected %h/%h",
               got_addr.raw, got_wr, exp_addr.raw, exp_wr);
      err_cnt++;
    end else if (exp_wr && got_data !== exp_data) begin
      $display("Error mem_req_wdata: got %h expected %h", got_data, exp_data);
      err_cnt++;
    end
  endtask

  // Compares CPU responses against the reference queue
  always @(negedge clk) begin
    if (rst_n && cpu_rsp_valid) begin
      if (exp_rsp.size() == 0) begin
        $display("A CPU response arrived with no request outstanding");
        err_cnt++;
      end else begin
        check_word("cpu_rsp_rdata", cpu_rsp_rdata, exp_rsp.pop_front());
      end
    end
  end

  // Memory model with delayed read responses and credit returns
  always @(negedge clk) begin
    mem_credit <= 1'b0;
    mem_rsp_valid <= 1'b0;
    if (!hold_credits && credit_due.size() > 0 && credit_due[0] <= cyc) begin
      void'(credit_due.pop_front());
      mem_credit <= 1'b1;
    end
    if (rsp_due.size() > 0 && rsp_due[0] <= cyc) begin
      void'(rsp_due.pop_front());
      mem_rsp_valid <= 1'b1;
      mem_rsp_rdata <= rsp_data.pop_front();
    end
    if (rst_n && mem_req_valid) begin
      mem_req_cnt++;
      if (exp_mem_addr.size() == 0) begin
        $display("The DUT issued a memory request that the reference did not expect");
        err_cnt++;
      end else begin
        check_mem_req(mem_req_addr, mem_req_write, mem_req_wdata, exp_mem_addr.pop_front(),
                      exp_mem_wr.pop_front(), exp_mem_data.pop_front());
      end
      if (mem_req_write) begin
        mem_blk[mem_req_addr] = mem_req_wdata;
      end else begin
        rsp_due.push_back(cyc + 1 + int'(lfsr_bits(delay_lfsr, 3)));
        rsp_data.push_back(mem_blk.exists(mem_req_addr) ? mem_blk[mem_req_addr]
                                                        : init_block(mem_req_addr));
      end
      credit_due.push_back(cyc + 1 + int'(lfsr_bits(delay_lfsr, 2)));
    end
  end

  // One request, returns cycles from drive to response
  task automatic do_req(cache_addr_u a, logic wr, logic [31:0] wd, output int lat);
    int c0;
    check_flag("cpu_req_ready", cpu_req_ready, 1'b1);  // Idle before the request
    exp_rsp.push_back(ref_access(a, wr, wd));
    cpu_req_valid <= 1'b1;
    cpu_req_addr <= a.raw;
    cpu_req_write <= wr;
    cpu_req_wdata <= wd;
    c0 = cyc;
    @(negedge clk);
    cpu_req_valid <= 1'b0;
    while (!cpu_rsp_valid) begin
      check_flag("cpu_req_ready", cpu_req_ready, 1'b0);  // Busy until the response
      @(negedge clk);
    end
    check_flag("cpu_req_ready", cpu_req_ready, 1'b1);
    lat = cyc - c0;
  endtask

  function automatic cache_addr_u make_addr(int tag, int idx, int word);
    cache_addr_u a;
    a.raw = '0;
    a.f.tag = tag;
    a.f.index = idx;
    a.f.word = word;
    return a;
  endfunction

  task automatic report(string name, int errs_before);
    $display("%s: %s", name, (err_cnt == errs_before) ? "ok" : "FAILED");
  endtask

  initial begin
    wait (cyc >= LIMIT);
    $display("Run stopped at cycle %0d because a response never arrived", cyc);
    $display("Checks failed");
    $finish;
  end

  initial begin
    int lat;
    int e0;
    int n0;
    cache_addr_u a;
    logic wr;
    rst_n = 1'b0;
    cpu_req_valid = 0;
    cpu_req_addr = 0;
    cpu_req_write = 0;
    cpu_req_wdata = 0;
    mem_credit = 0;
    mem_rsp_valid = 0;
    mem_rsp_rdata = 0;
    for (int s = 0; s < `CACHE_SETS; s++) begin
      for (int w = 0; w < `CACHE_WAYS; w++) begin
        ref_meta[s][w] = '{valid: 1'b0, dirty: 1'b0, age: w[1:0], tag: '0};
      end
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    e0 = err_cnt;
    n0 = mem_req_cnt;
    do_req(make_addr(26'h12345, 1, 2), 1'b0, '0, lat);
    if (mem_req_cnt != n0 + 1) begin
      $display("Cold read miss did not issue exactly one memory request");
      err_cnt++;
    end
    report("test 1 cold read miss", e0);

    e0 = err_cnt;
    n0 = mem_req_cnt;
    do_req(make_addr(26'h12345, 1, 2), 1'b0, '0, lat);
    if (lat != 2 || mem_req_cnt != n0) begin
      $display("Read hit took %0d cycles or touched memory", lat);
      err_cnt++;
    end
    report("test 2 read hit", e0);

    e0 = err_cnt;
    do_req(make_addr(26'h12345, 1, 1), 1'b1, 32'hcafe_f00d, lat);
    for (int w = 0; w < 4; w++) do_req(make_addr(26'h12345, 1, w), 1'b0, '0, lat);
    report("test 3 write then read", e0);

    e0 = err_cnt;
    for (int t = 1; t <= 4; t++) do_req(make_addr(t, 5, t % 4), 1'b1, 32'h1000 + t, lat);
    do_req(make_addr(5, 5, 0), 1'b0, '0, lat);  // Evicts the dirty oldest line
    do_req(make_addr(1, 5, 1), 1'b0, '0, lat);
    report("test 4 eviction", e0);

    e0 = err_cnt;
    repeat (12) @(negedge clk);
    hold_credits = 1;
    do_req(make_addr(7, 9, 0), 1'b0, '0, lat);
    do_req(make_addr(7, 10, 0), 1'b0, '0, lat);
    n0 = mem_req_cnt;
    fork
      do_req(make_addr(7, 11, 3), 1'b0, '0, lat);
      begin
        repeat (20) @(negedge clk);
        if (mem_req_cnt != n0) begin
          $display("A memory request was issued while no credit was left");
          err_cnt++;
        end
        hold_credits = 0;
      end
    join
    report("test 5 credit back-pressure", e0);

    e0 = err_cnt;
    for (int i = 0; i < NUM_RAND; i++) begin
      a = make_addr(lfsr_bits(stim_lfsr, 3), lfsr_bits(stim_lfsr, 2), lfsr_bits(stim_lfsr, 2));
      wr = lfsr_bits(stim_lfsr, 1);
      do_req(a, wr, lfsr_bits(stim_lfsr, 32), lat);
    end
    report("test 6 random mix", e0);

    repeat (20) @(negedge clk);
    if (exp_rsp.size() != 0 || exp_mem_addr.size() != 0) begin
      $display("Expected responses or memory requests never appeared");
      err_cnt++;
    end
    $display("Done at cycle %0d with %0d errors", cyc, err_cnt);
    if (err_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
+incdir+hdl
hdl/cache_pkg.sv
hdl/way_if.sv
hdl/way_array.sv
hdl/way_select.sv
hdl/cache_fsm.sv
hdl/cache_top.sv
verification/tb_cache.sv

//--- Makefile
VERILATOR ?= verilator
TB_TOP    ?= tb_cache
RTL_TOP   ?= cache_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o $(TB_TOP)
	-./$(BUILD_DIR)/$(TB_TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
